// File: ext_harness.f
+incdir+tests
rtl/ext_pkg.sv
rtl/obi_if.sv
rtl/reg_if.sv
rtl/obi_arbiter.sv
rtl/slow_memory.sv
rtl/memcopy_periph.sv
rtl/gpio_cnt.sv
rtl/ext_harness.sv
tests/tb_ext_harness.sv

// File: rtl/ext_harness.sv
/*
 * External device harness top
 * Host OBI and register ports into arbiter, slow memory, copy engine, GPIO counter
 */
`timescale 1ns/100ps

module ext_harness (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Host OBI port
  input  logic                      host_req_i,
  input  logic                      host_we_i,
  input  logic [ext_pkg::ADDR_W-1:0] host_addr_i,
  input  logic [ext_pkg::DATA_W-1:0] host_wdata_i,
  output logic                      host_gnt_o,
  output logic                      host_rvalid_o,
  output logic [ext_pkg::DATA_W-1:0] host_rdata_o,
  // Register bus
  input  logic                      reg_valid_i,
  input  logic                      reg_write_i,
  input  logic [ext_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [ext_pkg::DATA_W-1:0] reg_wdata_i,
  output logic                      reg_ready_o,
  output logic [ext_pkg::DATA_W-1:0] reg_rdata_o,
  // Interrupt and GPIO
  output logic                      copy_intr_o,
  input  logic                      gpio_i,
  output logic                      gpio_o
);
  import ext_pkg::*;

  obi_if host_bus ();
  obi_if copy_bus ();
  obi_if mem_bus ();
  reg_if cfg_bus ();

  assign host_bus.req   = host_req_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_wdata_i;
  assign host_gnt_o     = host_bus.gnt;
  assign host_rvalid_o  = host_bus.rvalid;
  assign host_rdata_o   = host_bus.rdata;

  assign cfg_bus.valid = reg_valid_i;
  assign cfg_bus.write = reg_write_i;
  assign cfg_bus.addr  = reg_addr_i;
  assign cfg_bus.wdata = reg_wdata_i;
  assign reg_ready_o   = cfg_bus.ready;
  assign reg_rdata_o   = cfg_bus.rdata;

  obi_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .host_port (host_bus),
    .copy_port (copy_bus),
    .mem_port  (mem_bus)
  );

  slow_memory u_slow_mem (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .mem_port (mem_bus)
  );

  memcopy_periph u_memcopy (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_port    (cfg_bus),
    .copy_port   (copy_bus),
    .copy_intr_o (copy_intr_o)
  );

  gpio_cnt #(
    .CNT_MAX (GPIO_CNT_MAX)
  ) u_gpio_cnt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o)
  );

endmodule

// File: rtl/ext_pkg.sv
/*
 * External device subsystem package
 * Bus widths, memory depth, register map and counter limit
 */
package ext_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Slow memory, indexed by address bits 8 to 2
  localparam int unsigned MEM_WORDS = 128;
  localparam int unsigned MEM_IDX_W = 7;

  // Copy engine register map
  localparam logic [ADDR_W-1:0] REG_SRC_OFFS    = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] REG_DST_OFFS    = 32'h0000_0004;
  localparam logic [ADDR_W-1:0] REG_SIZE_OFFS   = 32'h0000_0008;
  localparam logic [ADDR_W-1:0] REG_STATUS_OFFS = 32'h0000_000C;

  // STATUS bit positions
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

  // GPIO high-time counter limit
  localparam int unsigned GPIO_CNT_MAX = 16;

  // Arbiter masters, host first
  localparam int unsigned NUM_MASTERS = 2;
  localparam int unsigned MST_IDX_W   = $clog2(NUM_MASTERS);
  localparam logic [MST_IDX_W-1:0] HOST_MST = MST_IDX_W'(0);
  localparam logic [MST_IDX_W-1:0] COPY_MST = MST_IDX_W'(1);

endpackage

// File: rtl/gpio_cnt.sv
/*
 * GPIO high-time counter
 * Pulses the output once every CNT_MAX cycles of high input
 */
`timescale 1ns/100ps

module gpio_cnt #(
  parameter int unsigned CNT_MAX = ext_pkg::GPIO_CNT_MAX
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic gpio_i,
  output logic gpio_o
);

  localparam int unsigned CNT_W = $clog2(CNT_MAX + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             pulse_q;

  assign gpio_o = pulse_q;

  // Low cycles hold the count
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q   <= '0;
      pulse_q <= 1'b0;
    end else begin
      pulse_q <= 1'b0;
      if (gpio_i) begin
        if (cnt_q == CNT_W'(CNT_MAX - 1)) begin
          cnt_q   <= '0;
          pulse_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + CNT_W'(1);
        end
      end
    end
  end

endmodule

// File: rtl/memcopy_periph.sv
/*
 * Memory copy peripheral
 * Register-programmed word copy over an OBI master port with done interrupt
 */
`timescale 1ns/100ps

module memcopy_periph (
  input  logic   clk_i,
  input  logic   rst_n_i,
  reg_if.device  cfg_port,
  obi_if.manager copy_port,
  output logic   copy_intr_o
);
  import ext_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_WR_REQ,
    ST_WR_WAIT
  } state_e;

  state_e            state_q;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [DATA_W-1:0] size_q;
  logic [ADDR_W-1:0] rd_addr_q;
  logic [ADDR_W-1:0] wr_addr_q;
  logic [DATA_W-1:0] left_q;
  logic [DATA_W-1:0] data_q;
  logic              done_q;
  logic              intr_q;
  logic              busy;
  logic              cfg_wr;

  assign busy   = (state_q != ST_IDLE);
  // Config writes are dropped while a copy runs
  assign cfg_wr = cfg_port.valid && cfg_port.write && !busy;

  assign cfg_port.ready = cfg_port.valid;

  always_comb begin
    cfg_port.rdata = '0;
    if (cfg_port.addr == REG_SRC_OFFS) begin
      cfg_port.rdata = src_q;
    end else if (cfg_port.addr == REG_DST_OFFS) begin
      cfg_port.rdata = dst_q;
    end else if (cfg_port.addr == REG_SIZE_OFFS) begin
      cfg_port.rdata = size_q;
    end else if (cfg_port.addr == REG_STATUS_OFFS) begin
      cfg_port.rdata[STATUS_BUSY_BIT] = busy;
      cfg_port.rdata[STATUS_DONE_BIT] = done_q;
    end
  end

  // OBI request fields
  assign copy_port.req   = (state_q == ST_RD_REQ) || (state_q == ST_WR_REQ);
  assign copy_port.we    = (state_q == ST_WR_REQ);
  assign copy_port.addr  = (state_q == ST_WR_REQ) ? wr_addr_q : rd_addr_q;
  assign copy_port.wdata = data_q;

  assign copy_intr_o = intr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      src_q     <= '0;
      dst_q     <= '0;
      size_q    <= '0;
      rd_addr_q <= '0;
      wr_addr_q <= '0;
      left_q    <= '0;
      done_q    <= 1'b0;
      intr_q    <= 1'b0;
    end else begin
      intr_q <= 1'b0;
      if (cfg_wr) begin
        if (cfg_port.addr == REG_SRC_OFFS) begin
          src_q <= cfg_port.wdata;
        end else if (cfg_port.addr == REG_DST_OFFS) begin
          dst_q <= cfg_port.wdata;
        end else if (cfg_port.addr == REG_SIZE_OFFS) begin
          size_q <= cfg_port.wdata;
          if (cfg_port.wdata == '0) begin
            // Nothing to move, finish at once
            done_q <= 1'b1;
            intr_q <= 1'b1;
          end else begin
            done_q    <= 1'b0;
            state_q   <= ST_RD_REQ;
            rd_addr_q <= src_q;
            wr_addr_q <= dst_q;
            left_q    <= cfg_port.wdata;
          end
        end
      end
      case (state_q)
        ST_IDLE: ;
        ST_RD_REQ: begin
          if (copy_port.gnt) begin
            state_q <= ST_RD_WAIT;
          end
        end
        ST_RD_WAIT: begin
          if (copy_port.rvalid) begin
            state_q <= ST_WR_REQ;
          end
        end
        ST_WR_REQ: begin
          if (copy_port.gnt) begin
            state_q <= ST_WR_WAIT;
          end
        end
        ST_WR_WAIT: begin
          if (copy_port.rvalid) begin
            rd_addr_q <= rd_addr_q + ADDR_W'(4);
            wr_addr_q <= wr_addr_q + ADDR_W'(4);
            left_q    <= left_q - DATA_W'(1);
            if (left_q == DATA_W'(1)) begin
              state_q <= ST_IDLE;
              done_q  <= 1'b1;
              intr_q  <= 1'b1;
            end else begin
              state_q <= ST_RD_REQ;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Word in flight between read and write
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_RD_WAIT) && copy_port.rvalid) begin
      data_q <= copy_port.rdata;
    end
  end

  a_no_req_when_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !busy |-> !copy_port.req);

endmodule

// File: rtl/obi_arbiter.sv
/*
 * Two-master OBI arbiter
 * Round-robin choice, locked to the owner until its response returns
 */
`timescale 1ns/100ps

module obi_arbiter (
  input logic          clk_i,
  input logic          rst_n_i,
  obi_if.subordinate   host_port,
  obi_if.subordinate   copy_port,
  obi_if.manager       mem_port
);
  import ext_pkg::*;

  logic                 locked_q;
  logic [MST_IDX_W-1:0] owner_q;
  logic [MST_IDX_W-1:0] prefer_q;
  logic [MST_IDX_W-1:0] winner;
  logic [MST_IDX_W-1:0] sel;

  // Preferred master wins a tie
  always_comb begin
    if (host_port.req && copy_port.req) begin
      winner = prefer_q;
    end else if (copy_port.req) begin
      winner = COPY_MST;
    end else begin
      winner = HOST_MST;
    end
  end

  assign sel = locked_q ? owner_q : winner;

  // Request path follows the selected master
  always_comb begin
    if (sel == COPY_MST) begin
      mem_port.req   = copy_port.req;
      mem_port.we    = copy_port.we;
      mem_port.addr  = copy_port.addr;
      mem_port.wdata = copy_port.wdata;
    end else begin
      mem_port.req   = host_port.req;
      mem_port.we    = host_port.we;
      mem_port.addr  = host_port.addr;
      mem_port.wdata = host_port.wdata;
    end
  end

  // Grant and rvalid only reach the owner
  assign host_port.gnt    = mem_port.gnt && (sel == HOST_MST);
  assign copy_port.gnt    = mem_port.gnt && (sel == COPY_MST);
  assign host_port.rvalid = mem_port.rvalid && locked_q && (owner_q == HOST_MST);
  assign copy_port.rvalid = mem_port.rvalid && locked_q && (owner_q == COPY_MST);
  assign host_port.rdata  = mem_port.rdata;
  assign copy_port.rdata  = mem_port.rdata;
  assign host_port.err    = mem_port.err;
  assign copy_port.err    = mem_port.err;

  // Lock from the first forwarded request to its response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      locked_q <= 1'b0;
      owner_q  <= HOST_MST;
      prefer_q <= HOST_MST;
    end else if (!locked_q) begin
      if (mem_port.req) begin
        locked_q <= 1'b1;
        owner_q  <= winner;
      end
    end else if (mem_port.rvalid) begin
      locked_q <= 1'b0;
      prefer_q <= (owner_q == HOST_MST) ? COPY_MST : HOST_MST;
    end
  end

  a_one_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_port.gnt && copy_port.gnt));

endmodule

// File: rtl/obi_if.sv
/*
 * OBI bus interface
 * Request fields from the manager, grant and response from the subordinate
 */
`timescale 1ns/100ps

interface obi_if;
  import ext_pkg::*;

  // Request channel
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;

  // Grant and response channel
  logic              gnt;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic              err;

  modport manager (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport subordinate (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

// File: rtl/reg_if.sv
/*
 * Register bus interface
 * Single-cycle valid/ready access from host to device
 */
`timescale 1ns/100ps

interface reg_if;
  import ext_pkg::*;

  logic              valid;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              ready;
  logic [DATA_W-1:0] rdata;

  modport host (
    output valid, write, addr, wdata,
    input  ready, rdata
  );

  modport device (
    input  valid, write, addr, wdata,
    output ready, rdata
  );

endinterface

// File: rtl/slow_memory.sv
/*
 * Slow word memory on an OBI subordinate port
 * LFSR-chosen grant delay of 0 to 3 cycles, response one cycle after grant
 */
`timescale 1ns/100ps

module slow_memory (
  input logic        clk_i,
  input logic        rst_n_i,
  obi_if.subordinate mem_port
);
  import ext_pkg::*;

  logic [DATA_W-1:0]    mem_q [MEM_WORDS];
  logic [3:0]           lfsr_q;
  logic                 active_q;
  logic [1:0]           wait_q;
  logic                 rvalid_q;
  logic                 err_q;
  logic [DATA_W-1:0]    rdata_q;
  logic [MEM_IDX_W-1:0] idx;
  logic                 oob;

  assign idx = mem_port.addr[MEM_IDX_W+1:2];
  // Anything above the word range is flagged as an error
  assign oob = |mem_port.addr[ADDR_W-1:MEM_IDX_W+2];

  // Zero wait grants in the cycle the request shows up
  assign mem_port.gnt = mem_port.req && (active_q ? (wait_q == 2'd0) : (lfsr_q[1:0] == 2'd0));

  assign mem_port.rvalid = rvalid_q;
  assign mem_port.rdata  = rdata_q;
  assign mem_port.err    = err_q;

  // x^4 + x^3 + 1, free running
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lfsr_q <= 4'b1001;
    end else begin
      lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
    end
  end

  // Wait counter, loaded on the first cycle of a request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      wait_q   <= 2'd0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= mem_port.gnt;
      if (mem_port.gnt) begin
        active_q <= 1'b0;
        err_q    <= oob;
      end else if (mem_port.req && !active_q) begin
        active_q <= 1'b1;
        wait_q   <= lfsr_q[1:0] - 2'd1;
      end else if (active_q) begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  // Storage and read data
  always_ff @(posedge clk_i) begin
    if (mem_port.gnt) begin
      if (mem_port.we && !oob) begin
        mem_q[idx] <= mem_port.wdata;
      end
      rdata_q <= mem_q[idx];
    end
  end

  a_rvalid_after_gnt : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_port.rvalid |-> $past(mem_port.gnt));

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the harness testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_ext_harness -Mdir obj_dir -f ext_harness.f > sim.log 2>&1 &&
  ./obj_dir/Vtb_ext_harness >> sim.log 2>&1

grep -q "^TESTBENCH PASSED$" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed, see sim.log"; exit 1; }

// File: tests/tb_ext_tasks.svh
/*
 * Host OBI and register bus access tasks with value checking
 */

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("** Error %s: expected 0x%08h, actual 0x%08h",
                          name, expected, actual));
    end
  endtask

  // Grant is taken at the next rising edge, response arrives after it
  task automatic wait_host_response();
    #1;
    while (!host_gnt) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    host_req = 1'b0;
    #1;
    while (!host_rvalid) begin
      @(negedge clk);
      #1;
    end
  endtask

  task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    wait_host_response();
  endtask

  // Expected word comes from the reference image at issue time
  task automatic host_read(input logic [ADDR_W-1:0] addr, input string name);
    @(negedge clk);
    exp_name  = name;
    exp_data  = ref_mem[addr[MEM_IDX_W+1:2]];
    rd_pend   = 1'b1;
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    wait_host_response();
    rd_pend = 1'b0;
  endtask

  task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_valid = 1'b0;
    reg_wr    = 1'b0;
  endtask

  task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_wr    = 1'b0;
    reg_addr  = addr;
    #1;
    if (!reg_ready) begin
      abort_run("Register bus did not raise ready during a read");
    end
    data = reg_rdata;
    @(negedge clk);
    reg_valid = 1'b0;
  endtask

// File: tests/tb_ext_harness.sv
/*
 * Testbench for the external device harness
 * Host memory traffic, copy engine programming and GPIO high-time counting
 */
`timescale 1ns/100ps

module tb_ext_harness;
  import ext_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int GPIO_HIGHS     = 100;

  logic              clk;
  logic              rst_n;
  logic              host_req;
  logic              host_we;
  logic [ADDR_W-1:0] host_addr;
  logic [DATA_W-1:0] host_wdata;
  logic              host_gnt;
  logic              host_rvalid;
  logic [DATA_W-1:0] host_rdata;
  logic              reg_valid;
  logic              reg_wr;
  logic [ADDR_W-1:0] reg_addr;
  logic [DATA_W-1:0] reg_wdata;
  logic              reg_ready;
  logic [DATA_W-1:0] reg_rdata;
  logic              copy_intr;
  logic              gpio_in;
  logic              gpio_out;

  // Mirror of the slow memory contents
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];
  integer            seed;
  int                cycle_cnt = 0;
  int                intr_cnt = 0;
  int                gpio_pulses = 0;
  logic              rd_pend = 1'b0;
  string             exp_name;
  logic [DATA_W-1:0] exp_data;

  ext_harness UUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .host_req_i    (host_req),
    .host_we_i     (host_we),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_wr),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_ready_o   (reg_ready),
    .reg_rdata_o   (reg_rdata),
    .copy_intr_o   (copy_intr),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out)
  );

  `include "tb_ext_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Word-by-word copy applied to the reference image
  function automatic void ref_copy(input logic [ADDR_W-1:0] src,
                                   input logic [ADDR_W-1:0] dst, input int words);
    logic [MEM_IDX_W-1:0] s_idx;
    logic [MEM_IDX_W-1:0] d_idx;
    s_idx = src[MEM_IDX_W+1:2];
    d_idx = dst[MEM_IDX_W+1:2];
    for (int k = 0; k < words; k++) begin
      ref_mem[d_idx] = ref_mem[s_idx];
      s_idx = s_idx + MEM_IDX_W'(1);
      d_idx = d_idx + MEM_IDX_W'(1);
    end
  endfunction

  task automatic verify_memory(input string name);
    for (int i = 0; i < MEM_WORDS; i++) begin
      host_read(ADDR_W'(i * 4), name);
    end
  endtask

  task automatic start_copy(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                            input int words);
    reg_write(REG_SRC_OFFS, src);
    reg_write(REG_DST_OFFS, dst);
    reg_write(REG_SIZE_OFFS, DATA_W'(words));
  endtask

  // Event counters and the read data comparison
  always @(negedge clk) begin
    if (copy_intr) intr_cnt++;
    if (gpio_out) gpio_pulses++;
    if (rd_pend && host_rvalid) begin
      check_value(exp_name, exp_data, host_rdata);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    logic [DATA_W-1:0] rd;
    int                n0;
    int                highs;
    int                run;
    int                gap;
    seed       = 32'h3647;
    rst_n      = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    reg_valid  = 1'b0;
    reg_wr     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    gpio_in    = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Fill every word, then read it all back
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[MEM_IDX_W'(i)] = $random(seed);
      host_write(ADDR_W'(i * 4), ref_mem[MEM_IDX_W'(i)]);
    end
    verify_memory("fill_readback");

    // Zero length finishes at once, done still clear from reset
    n0 = intr_cnt;
    reg_write(REG_SIZE_OFFS, '0);
    wait (intr_cnt != n0);
    reg_read(REG_STATUS_OFFS, rd);
    check_value("zero_status", DATA_W'(1 << STATUS_DONE_BIT), rd);
    repeat (4) @(negedge clk);
    check_value("zero_intr_count", n0 + 1, intr_cnt);

    // Words 0..19 to 64..83
    n0 = intr_cnt;
    start_copy(32'h000, 32'h100, 20);
    reg_read(REG_STATUS_OFFS, rd);
    check_value("copy_busy_status", DATA_W'(1 << STATUS_BUSY_BIT), rd);
    wait (intr_cnt != n0);
    reg_read(REG_STATUS_OFFS, rd);
    check_value("copy_status", DATA_W'(1 << STATUS_DONE_BIT), rd);
    ref_copy(32'h000, 32'h100, 20);
    verify_memory("copy_20");

    // Second programming lands while busy and must be dropped
    n0 = intr_cnt;
    start_copy(32'h020, 32'h080, 20);
    start_copy(32'h040, 32'h0C0, 5);
    reg_read(REG_SRC_OFFS, rd);
    check_value("busy_src", 32'h020, rd);
    reg_read(REG_DST_OFFS, rd);
    check_value("busy_dst", 32'h080, rd);
    wait (intr_cnt != n0);
    ref_copy(32'h020, 32'h080, 20);
    verify_memory("busy_ignore");
    check_value("busy_intr_count", n0 + 1, intr_cnt);

    // Host traffic outside words 0..39 and 64..103 during a long copy
    n0 = intr_cnt;
    start_copy(32'h000, 32'h100, 40);
    for (int i = 0; i < 16; i++) begin
      ref_mem[MEM_IDX_W'(108 + i)] = $random(seed);
      host_write(ADDR_W'((108 + i) * 4), ref_mem[MEM_IDX_W'(108 + i)]);
      host_read(ADDR_W'((40 + i) * 4), "host_during_copy");
    end
    wait (intr_cnt != n0);
    ref_copy(32'h000, 32'h100, 40);
    verify_memory("copy_with_host");

    // Random high runs with random low gaps
    n0    = gpio_pulses;
    highs = 0;
    while (highs < GPIO_HIGHS) begin
      run = 1 + ($random(seed) & 7);
      if (run > GPIO_HIGHS - highs) run = GPIO_HIGHS - highs;
      gap = $random(seed) & 3;
      repeat (run) begin
        @(negedge clk);
        gpio_in = 1'b1;
      end
      repeat (gap) begin
        @(negedge clk);
        gpio_in = 1'b0;
      end
      highs += run;
    end
    @(negedge clk);
    gpio_in = 1'b0;
    repeat (3) @(negedge clk);
    check_value("gpio_pulses", GPIO_HIGHS / GPIO_CNT_MAX, gpio_pulses - n0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
